// ==== hw/slavespi_pkg.sv ====
//####################
// slave spi shared definitions
// register map and common types
//####################
package slavespi_pkg;

	localparam int KBD_W = 40; // keyboard matrix bits

	typedef logic [7:0]       byte_t;
	typedef logic [KBD_W-1:0] kbd_t;
	typedef logic [1:0]       rom_page_t;

	// high nibble selects the group
	localparam byte_t REG_KBD     = 8'h10;
	localparam byte_t REG_KBD_STB = 8'h11;

	localparam byte_t REG_MUS_X   = 8'h20;
	localparam byte_t REG_MUS_Y   = 8'h21;
	localparam byte_t REG_MUS_BTN = 8'h22;
	localparam byte_t REG_KJ      = 8'h23;

	localparam byte_t REG_RST     = 8'h30; // whole group

	localparam byte_t REG_WAIT    = 8'h40;
	localparam byte_t REG_GLU_ADR = 8'h41;
	localparam byte_t REG_COM_ADR = 8'h42;

	localparam byte_t REG_CFG0    = 8'h50; // whole group

	// returned for anything not readable
	localparam byte_t READ_IDLE = 8'hFF;

	// rom page field inside the reset register
	localparam int RSTROM_LSB = 4;

endpackage

// ==== hw/spi_frame_if.sv ====
//####################
// spi frame events
// from frame engine to register bank
//####################
`timescale 1ns/10ps

interface spi_frame_if import slavespi_pkg::*; ();

	byte_t regnum;    // register number of the current frame
	logic  in_frame;  // chip select low
	logic  bit_stb;   // data phase bit
	logic  bit_val;
	logic  frame_end; // chip select rose
	byte_t rd_data;   // back from the bank

	modport engine (
		output regnum,
		output in_frame,
		output bit_stb,
		output bit_val,
		output frame_end,
		input  rd_data
	);

	modport bank (
		input  regnum,
		input  in_frame,
		input  bit_stb,
		input  bit_val,
		input  frame_end,
		output rd_data
	);

endinterface

// ==== hw/spi_pin_sync.sv ====
//####################
// spi pin synchronizer
// resyncs cs/sck/data and finds edges
//####################
`timescale 1ns/10ps

module spi_pin_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  logic fclk,
	input  logic arst_n,
	input  logic spics_n,
	input  logic spick,
	input  logic spido,
	output logic cs_n,
	output logic cs_rise,
	output logic cs_fall,
	output logic sck_rise,
	output logic sdo
);

	// one extra stage on cs and sck for edge detection
	logic [SYNC_STAGES:0]   cs_sh;
	logic [SYNC_STAGES:0]   ck_sh;
	logic [SYNC_STAGES-1:0] do_sh;

	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
		begin
			cs_sh    <= '1; // deselected
			ck_sh    <= '0;
			do_sh    <= '0;
			cs_rise  <= 1'b0;
			cs_fall  <= 1'b0;
			sck_rise <= 1'b0;
		end
		else
		begin
			cs_sh <= {cs_sh[SYNC_STAGES-1:0], spics_n};
			ck_sh <= {ck_sh[SYNC_STAGES-1:0], spick};
			do_sh <= {do_sh[SYNC_STAGES-2+1-1:0], spido};

			// pulses one cycle after the synced level moves
			cs_rise  <=  cs_sh[SYNC_STAGES-1] & ~cs_sh[SYNC_STAGES];
			cs_fall  <= ~cs_sh[SYNC_STAGES-1] &  cs_sh[SYNC_STAGES];
			sck_rise <=  ck_sh[SYNC_STAGES-1] & ~ck_sh[SYNC_STAGES];
		end

	assign cs_n = cs_sh[SYNC_STAGES-1];
	assign sdo  = do_sh[SYNC_STAGES-1];

endmodule

// ==== hw/spi_frame_engine.sv ====
//####################
// spi frame engine
// register number and outgoing shifter
//####################
`timescale 1ns/10ps

module spi_frame_engine import slavespi_pkg::*; (
	input  logic  fclk,
	input  logic  arst_n,
	input  logic  cs_n,
	input  logic  cs_rise,
	input  logic  cs_fall,
	input  logic  sck_rise,
	input  logic  sdo,
	input  byte_t status_in,
	output logic  spidi,
	spi_frame_if.engine frm
);

	byte_t regnum_q;
	byte_t shift_q;

	// register number comes in lsb first while cs is high
	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
		begin
			regnum_q <= '0;
		end
		else if (cs_rise)
		begin
			regnum_q <= '0; // new frame header
		end
		else if (cs_n && sck_rise)
		begin
			regnum_q <= {sdo, regnum_q[7:1]};
		end

	// outgoing data reloaded on both cs edges
	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
		begin
			shift_q <= '0;
		end
		else if (cs_rise)
		begin
			shift_q <= status_in; // shown during the header
		end
		else if (cs_fall)
		begin
			shift_q <= frm.rd_data;
		end
		else if (sck_rise)
		begin
			shift_q <= {1'b0, shift_q[7:1]};
		end

	assign spidi = shift_q[0];

	// frame events towards the bank
	assign frm.regnum    = regnum_q;
	assign frm.in_frame  = ~cs_n;
	assign frm.bit_stb   = sck_rise & ~cs_n; // data phase only
	assign frm.bit_val   = sdo;
	assign frm.frame_end = cs_rise;

endmodule

// ==== hw/spi_reg_bank.sv ====
//####################
// spi register bank
// decode, data shift-in, strobes, readback
//####################
`timescale 1ns/10ps

module spi_reg_bank import slavespi_pkg::*; #(
	parameter int KBD_WIDTH = KBD_W
) (
	input  logic      fclk,
	input  logic      arst_n,
	spi_frame_if.bank frm,
	input  byte_t     wait_write,
	input  byte_t     gluclock_addr,
	input  logic [2:0] comport_addr,
	output kbd_t      kbd_out,
	output logic      kbd_stb,
	output logic      mus_xstb,
	output logic      mus_ystb,
	output logic      mus_btnstb,
	output logic      kj_stb,
	output logic      genrst,
	output byte_t     mus_out,
	output byte_t     config0,
	output rom_page_t rstrom,
	output byte_t     wait_data,
	output logic      wait_done
);

	logic [3:0] grp;
	logic [1:0] sub;

	logic sel_kbd, sel_kbd_stb;
	logic sel_mus_x, sel_mus_y, sel_mus_btn, sel_kj, sel_mus;
	logic sel_rst, sel_cfg;
	logic sel_wait, sel_glu, sel_com;

	logic [KBD_WIDTH-1:0] kbd_reg;
	byte_t mus_reg;
	byte_t rst_reg;
	byte_t wait_sh;
	byte_t cfg_sh; // shifted in before commit
	byte_t rd_mux;

	assign grp = frm.regnum[7:4];
	assign sub = frm.regnum[1:0];

	// $1x by bit 0
	assign sel_kbd     = (grp == REG_KBD[7:4])     && (sub[0] == REG_KBD[0]);
	assign sel_kbd_stb = (grp == REG_KBD_STB[7:4]) && (sub[0] == REG_KBD_STB[0]);

	// $2x by bits 1:0
	assign sel_mus_x   = (grp == REG_MUS_X[7:4])   && (sub == REG_MUS_X[1:0]);
	assign sel_mus_y   = (grp == REG_MUS_Y[7:4])   && (sub == REG_MUS_Y[1:0]);
	assign sel_mus_btn = (grp == REG_MUS_BTN[7:4]) && (sub == REG_MUS_BTN[1:0]);
	assign sel_kj      = (grp == REG_KJ[7:4])      && (sub == REG_KJ[1:0]);
	assign sel_mus     = sel_mus_x | sel_mus_y | sel_mus_btn | sel_kj;

	assign sel_rst = (grp == REG_RST[7:4]);
	assign sel_cfg = (grp == REG_CFG0[7:4]);

	// $4x by bits 1:0 and $43 hits nothing
	assign sel_wait = (grp == REG_WAIT[7:4])    && (sub == REG_WAIT[1:0]);
	assign sel_glu  = (grp == REG_GLU_ADR[7:4]) && (sub == REG_GLU_ADR[1:0]);
	assign sel_com  = (grp == REG_COM_ADR[7:4]) && (sub == REG_COM_ADR[1:0]);

	// shift registers and config commit
	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
		begin
			kbd_reg <= '0;
			mus_reg <= '0;
			rst_reg <= '0;
			config0 <= '0;
		end
		else
		begin
			if (frm.bit_stb && sel_kbd)
				kbd_reg <= {frm.bit_val, kbd_reg[KBD_WIDTH-1:1]};
			if (frm.bit_stb && sel_mus)
				mus_reg <= {frm.bit_val, mus_reg[7:1]};
			if (frm.bit_stb && sel_rst)
				rst_reg <= {frm.bit_val, rst_reg[7:1]};
			if (frm.frame_end && sel_cfg)
				config0 <= cfg_sh; // commit at end of frame
		end

	always_ff @(posedge fclk)
	begin
		if (frm.bit_stb && sel_wait)
			wait_sh <= {frm.bit_val, wait_sh[7:1]};
		if (frm.bit_stb && sel_cfg)
			cfg_sh <= {frm.bit_val, cfg_sh[7:1]};
	end

	// readback mux
	always_comb
	begin
		if (sel_wait)
			rd_mux = wait_write;
		else if (sel_glu)
			rd_mux = gluclock_addr;
		else if (sel_com)
			rd_mux = {5'd0, comport_addr};
		else
			rd_mux = READ_IDLE;
	end

	assign frm.rd_data = frm.in_frame ? rd_mux : READ_IDLE; // only inside a frame

	assign kbd_out    = kbd_t'(kbd_reg);
	assign kbd_stb    = sel_kbd_stb && frm.frame_end;
	assign mus_out    = mus_reg;
	assign mus_xstb   = sel_mus_x   && frm.frame_end;
	assign mus_ystb   = sel_mus_y   && frm.frame_end;
	assign mus_btnstb = sel_mus_btn && frm.frame_end;
	assign kj_stb     = sel_kj      && frm.frame_end;
	assign genrst     = sel_rst     && frm.frame_end;
	assign rstrom     = rst_reg[RSTROM_LSB +: $bits(rom_page_t)];
	assign wait_data  = wait_sh;
	assign wait_done  = sel_wait && frm.frame_end;

endmodule

// ==== hw/wait_port.sv ====
//####################
// wait data port
// four-phase req/ack towards the system
//####################
`timescale 1ns/10ps

module wait_port import slavespi_pkg::*; (
	input  logic  fclk,
	input  logic  arst_n,
	input  byte_t wait_data,
	input  logic  wait_done,
	input  logic  wait_ack,
	output logic  wait_req,
	output byte_t wait_read
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,  // req high until ack
		ST_DROP  // req low and ack still high
	} state_t;

	state_t state;

	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
		begin
			state <= ST_IDLE;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (wait_done)
						state <= ST_REQ;
				ST_REQ:
					if (wait_ack)
						state <= ST_DROP;
				ST_DROP:
					if (!wait_ack)
						state <= ST_IDLE; // ready for next byte
				default:
					state <= ST_IDLE;
			endcase
		end

	// writes during a handshake are dropped
	always_ff @(posedge fclk)
	begin
		if (state == ST_IDLE && wait_done)
			wait_read <= wait_data;
	end

	assign wait_req = (state == ST_REQ);

endmodule

// ==== hw/slavespi_top.sv ====
//####################
// spi slave register block
//####################
`timescale 1ns/10ps

module slavespi_top import slavespi_pkg::*; #(
	parameter int SYNC_STAGES = 2,
	parameter int KBD_WIDTH   = KBD_W
) (
	input  logic       fclk,
	input  logic       arst_n,
	input  logic       spics_n,
	input  logic       spick,
	input  logic       spido,
	output logic       spidi,
	input  byte_t      status_in,
	output kbd_t       kbd_out,
	output logic       kbd_stb,
	output byte_t      mus_out,
	output logic       mus_xstb,
	output logic       mus_ystb,
	output logic       mus_btnstb,
	output logic       kj_stb,
	input  byte_t      gluclock_addr,
	input  logic [2:0] comport_addr,
	input  byte_t      wait_write,
	output byte_t      wait_read,
	output logic       wait_req,
	input  logic       wait_ack,
	output byte_t      config0,
	output logic       genrst,
	output rom_page_t  rstrom
);

	logic  cs_n, cs_rise, cs_fall, sck_rise, sdo;
	byte_t wait_data;
	logic  wait_done;

	spi_frame_if frm ();

	spi_pin_sync #(
		.SYNC_STAGES (SYNC_STAGES)
	) u_sync (
		.fclk     (fclk),
		.arst_n   (arst_n),
		.spics_n  (spics_n),
		.spick    (spick),
		.spido    (spido),
		.cs_n     (cs_n),
		.cs_rise  (cs_rise),
		.cs_fall  (cs_fall),
		.sck_rise (sck_rise),
		.sdo      (sdo)
	);

	spi_frame_engine u_engine (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.cs_n      (cs_n),
		.cs_rise   (cs_rise),
		.cs_fall   (cs_fall),
		.sck_rise  (sck_rise),
		.sdo       (sdo),
		.status_in (status_in),
		.spidi     (spidi),
		.frm       (frm.engine)
	);

	spi_reg_bank #(
		.KBD_WIDTH (KBD_WIDTH)
	) u_bank (
		.fclk          (fclk),
		.arst_n        (arst_n),
		.frm           (frm.bank),
		.wait_write    (wait_write),
		.gluclock_addr (gluclock_addr),
		.comport_addr  (comport_addr),
		.kbd_out       (kbd_out),
		.kbd_stb       (kbd_stb),
		.mus_xstb      (mus_xstb),
		.mus_ystb      (mus_ystb),
		.mus_btnstb    (mus_btnstb),
		.kj_stb        (kj_stb),
		.genrst        (genrst),
		.mus_out       (mus_out),
		.config0       (config0),
		.rstrom        (rstrom),
		.wait_data     (wait_data),
		.wait_done     (wait_done)
	);

	wait_port u_wait (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.wait_data (wait_data),
		.wait_done (wait_done),
		.wait_ack  (wait_ack),
		.wait_req  (wait_req),
		.wait_read (wait_read)
	);

endmodule

// ==== verif/slavespi_props.sv ====
//####################
// slave spi assertions
// strobes and wait handshake
//####################
`timescale 1ns/10ps

module slavespi_props import slavespi_pkg::*; (
	input logic  fclk,
	input logic  arst_n,
	input logic  kbd_stb,
	input logic  mus_xstb,
	input logic  mus_ystb,
	input logic  mus_btnstb,
	input logic  kj_stb,
	input logic  genrst,
	input logic  wait_req,
	input logic  wait_ack,
	input byte_t wait_read
);

	logic [5:0] stb;

	assign stb = {kbd_stb, mus_xstb, mus_ystb, mus_btnstb, kj_stb, genrst};

	// no strobe runs into a second cycle
	stb_width: assert property (@(posedge fclk) disable iff (!arst_n)
		(stb & $past(stb)) == 6'd0)
		else $error("strobe held longer than one cycle");

	stb_single: assert property (@(posedge fclk) disable iff (!arst_n) $onehot0(stb))
		else $error("more than one strobe high at once");

	// req falls only after ack was seen
	req_hold: assert property (@(posedge fclk) disable iff (!arst_n)
		$fell(wait_req) |-> $past(wait_ack))
		else $error("wait_req dropped before wait_ack rose");

	data_stable: assert property (@(posedge fclk) disable iff (!arst_n)
		wait_req && $past(wait_req) |-> $stable(wait_read))
		else $error("wait_read changed while wait_req was high");

endmodule

bind slavespi_top slavespi_props u_props (
	.fclk       (fclk),
	.arst_n     (arst_n),
	.kbd_stb    (kbd_stb),
	.mus_xstb   (mus_xstb),
	.mus_ystb   (mus_ystb),
	.mus_btnstb (mus_btnstb),
	.kj_stb     (kj_stb),
	.genrst     (genrst),
	.wait_req   (wait_req),
	.wait_ack   (wait_ack),
	.wait_read  (wait_read)
);

// ==== verif/tb_slavespi.sv ====
//####################
// slave spi testbench
// plays golden frames as spi master
//####################
`timescale 1ns/10ps

module tb_slavespi import slavespi_pkg::*; ();

	logic       fclk;
	logic       arst_n;
	logic       spics_n, spick, spido, spidi;
	byte_t      status_in, gluclock_addr, wait_write;
	byte_t      mus_out, wait_read, config0;
	logic [2:0] comport_addr;
	kbd_t       kbd_out;
	logic       kbd_stb, mus_xstb, mus_ystb, mus_btnstb, kj_stb, genrst;
	logic       wait_req, wait_ack;
	rom_page_t  rstrom;

	logic [31:0] lfsr;
	byte_t       cfg_exp;   // config0 as last written
	int          cycles = 0;
	int          limit = 240; // reset and start-up frame, grows per line

	slavespi_top dut0 (.*);

	initial
	begin
		fclk = 1'b0;
		forever #20 fclk = ~fclk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	always @(posedge fclk)
	begin
		cycles++;
		if (cycles > limit)
			abort_run("run went past its cycle limit");
	end

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_kbd(input string name, input kbd_t exp, input kbd_t act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_page(input string name, input rom_page_t exp, input rom_page_t act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output byte_t v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	task automatic draw_inputs();
		byte_t com;
		rand_bits(8, status_in);
		rand_bits(8, gluclock_addr);
		rand_bits(3, com);
		comport_addr = com[2:0];
		$display("inputs: status_in=%h gluclock_addr=%h comport_addr=%h",
			status_in, gluclock_addr, comport_addr);
	endtask

	// strobe bits kbd, x, y, btn, kj, genrst
	function automatic logic [5:0] strobe_mask(input byte_t r);
		logic [5:0] m;
		m = '0;
		case (r[7:4])
			REG_KBD_STB[7:4]: m[5] = r[0];
			REG_MUS_X[7:4]:   m[4 - r[1:0]] = 1'b1;
			REG_RST[7:4]:     m[0] = 1'b1;
			default:          m = '0;
		endcase
		return m;
	endfunction

	task automatic shift_bit(input logic d, output logic q);
		spido = d;
		repeat (4) @(negedge fclk);
		q = spidi; // sampled before the rise
		spick = 1'b1;
		repeat (4) @(negedge fclk);
		spick = 1'b0;
	endtask

	task automatic run_frame(input byte_t r, input int bits, input logic [39:0] wd,
			output byte_t hdr, output byte_t rd);
		logic q;
		int i;
		hdr = '0;
		rd = '0;
		for (i = 0; i < 8; i++)
		begin
			shift_bit(r[i], q);
			hdr[i] = q;
		end
		@(negedge fclk);
		spics_n = 1'b0;
		repeat (4) @(negedge fclk);
		for (i = 0; i < bits; i++)
		begin
			shift_bit(wd[i], q);
			if (i < 8)
				rd[i] = q;
		end
		repeat (4) @(negedge fclk);
		draw_inputs(); // held for the next header
		spics_n = 1'b1;
	endtask

	task automatic settle_wait(input string name, input byte_t exp);
		int n;
		if (wait_ack)
		begin
			// port still waits for ack to drop so this byte is lost
			if (wait_req)
				abort_run($sformatf("%s: wait_req rose during a handshake", name));
			check_byte(name, exp, wait_read);
			wait_ack = 1'b0;
			repeat (2) @(negedge fclk);
		end
		else
		begin
			if (!wait_req)
				abort_run($sformatf("%s: no wait_req within 16 cycles of cs rising", name));
			check_byte(name, exp, wait_read);
			wait_ack = 1'b1;
			n = 0;
			while (wait_req && n < 16)
			begin
				@(negedge fclk);
				n++;
			end
			if (wait_req)
				abort_run($sformatf("%s: wait_req stayed high after wait_ack", name));
		end
	endtask

	task automatic check_frame(input string name, input byte_t r, input logic [39:0] exp);
		logic [5:0] mask;
		logic [5:0] seen;
		logic [5:0] stb;
		int i;
		mask = strobe_mask(r);
		seen = '0;
		for (i = 0; i < 16; i++)
		begin
			@(negedge fclk);
			stb = {kbd_stb, mus_xstb, mus_ystb, mus_btnstb, kj_stb, genrst};
			seen = seen | stb;
			if (stb[5])
				check_kbd(name, exp[KBD_W-1:0], kbd_out);
			if (|stb[4:1])
				check_byte(name, exp[7:0], mus_out);
			if (stb[0])
				check_page(name, exp[1:0], rstrom);
		end
		if (mask != '0 && seen == '0)
			abort_run($sformatf("%s: no strobe within 16 cycles of cs rising", name));
		check_byte({name, " strobes"}, {2'b00, mask}, {2'b00, seen});
		if (r[7:4] == REG_CFG0[7:4])
			cfg_exp = exp[7:0];
		check_byte({name, " config0"}, cfg_exp, config0);
		if (r[7:4] == REG_KBD[7:4] && r[0] == REG_KBD[0])
			check_kbd(name, exp[KBD_W-1:0], kbd_out);
		if (r[7:4] == REG_WAIT[7:4] && r[1:0] == REG_WAIT[1:0])
			settle_wait(name, exp[7:0]);
	endtask

	initial
	begin
		string       line, name, rd_s;
		byte_t       r, exp_hdr, exp_rd, hdr, rd;
		int          bits, fd, n;
		logic [39:0] wd, exp;
		arst_n = 1'b0;
		spics_n = 1'b1;
		spick = 1'b0;
		spido = 1'b0;
		status_in = '0;
		gluclock_addr = '0;
		comport_addr = '0;
		wait_write = 8'h96;
		wait_ack = 1'b0;
		lfsr = 32'h864c93c7;
		cfg_exp = '0;
		repeat (4) @(negedge fclk);
		arst_n = 1'b1;
		check_byte("reset config0", 8'h00, config0);
		check_byte("reset mus_out", 8'h00, mus_out);
		check_kbd("reset kbd_out", '0, kbd_out);
		check_page("reset rstrom", 2'b00, rstrom);
		if (wait_req || spidi || kbd_stb || mus_xstb || mus_ystb || mus_btnstb
				|| kj_stb || genrst)
			abort_run("strobes, wait_req or spidi not low after reset");
		// empty frame so the shifter holds status_in
		spics_n = 1'b0;
		repeat (8) @(negedge fclk);
		draw_inputs();
		spics_n = 1'b1;
		repeat (8) @(negedge fclk);
		fd = $fopen("verif/slavespi_golden.txt", "r");
		if (fd == 0)
			abort_run("could not open verif/slavespi_golden.txt");
		while ($fgets(line, fd) != 0)
		begin
			if (line.substr(0, 0) == "#")
				continue;
			n = $sscanf(line, "%s %h %d %h %s %h", name, r, bits, wd, rd_s, exp);
			if (n <= 0)
				continue;
			if (n != 6)
				abort_run($sformatf("golden line not understood: %s", line));
			limit += (bits + 16) * 8; // header, data and settling
			exp_hdr = status_in;
			if (rd_s == "rnd")
				exp_rd = (r[1:0] == REG_GLU_ADR[1:0]) ? gluclock_addr : {5'd0, comport_addr};
			else
				n = $sscanf(rd_s, "%h", exp_rd);
			run_frame(r, bits, wd, hdr, rd);
			check_byte({name, " header"}, exp_hdr, hdr);
			if (bits >= 8)
				check_byte({name, " read"}, exp_rd, rd);
			check_frame(name, r, exp);
		end
		$fclose(fd);
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== project.f ====
hw/slavespi_pkg.sv
hw/spi_frame_if.sv
hw/spi_pin_sync.sv
hw/spi_frame_engine.sv
hw/spi_reg_bank.sv
hw/wait_port.sv
hw/slavespi_top.sv
verif/slavespi_props.sv
verif/tb_slavespi.sv

// ==== Bender.yml ====
package:
  name: slavespi

sources:
  - hw/slavespi_pkg.sv
  - hw/spi_frame_if.sv
  - hw/spi_pin_sync.sv
  - hw/spi_frame_engine.sv
  - hw/spi_reg_bank.sv
  - hw/wait_port.sv
  - hw/slavespi_top.sv
  - target: simulation
    files:
      - verif/slavespi_props.sv
      - verif/tb_slavespi.sv

// ==== verif/slavespi_golden.txt ====
# name  reg  bits  write_data  read_byte  expected_out   (all hex except bits)
# read_byte rnd means the live gluclock_addr or comport_addr input
cfg_write    50  8 5a         ff  5a
kbd_write    10 40 123456789a ff  123456789a
kbd_strobe   11  8 00         ff  123456789a
mus_x        20  8 3c         ff  3c
mus_y        21  8 c5         ff  c5
mus_btn      22  8 07         ff  07
kj_byte      23  8 e1         ff  e1
rst_page2    30  8 25         ff  2
rst_page1    30  8 1b         ff  1
read_glu     41  8 00         rnd 0
read_com     42  8 00         rnd 0
read_none    43  8 00         ff  0
wait_first   40  8 a5         96  a5
wait_busy    40  8 3c         96  a5
wait_next    40  8 69         96  69
wait_busy2   40  8 0f         96  69
cfg_again    50  8 c3         ff  c3
